/* verilog/chipset_cfg.svh */
`ifndef CHIPSET_CFG_SVH
`define CHIPSET_CFG_SVH

// bus widths
`define ADDR_W 20
`define RAM_ADDR_W 21

// expanded memory
`define EMS_PAGES 4
`define EMS_MAP_W 6

// i/o port map
`define EMS_PORT_BASE 16'h0260
`define LPT_PORT 16'h0378
// matched on address bits 15 to 3
`define NMI_MASK_PORT 16'h00A0

// chip selects below 0x100
`define PERIPH_COUNT 8

`endif

/* verilog/chipset_pkg.sv */
`include "chipset_cfg.svh"

package chipset_pkg;

	typedef logic [`ADDR_W-1:0] cpu_addr_t;
	typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [7:0] bus_byte_t;

	// one mapped 16k page number
	typedef logic [`EMS_MAP_W-1:0] ems_entry_t;
	typedef ems_entry_t [`EMS_PAGES-1:0] ems_map_t;

	// select group, all active high
	typedef struct packed {
		logic ems;
		logic lpt;
		logic nmi_mask;
		logic ram;
	} io_sel_t;

endpackage

/* verilog/cpu_bus_if.sv */
`timescale 1ns/1ps

interface cpu_bus_if import chipset_pkg::*; ();

	cpu_addr_t address;
	bus_byte_t data;
	logic io_read_n;
	logic io_write_n;
	logic memory_read_n;
	logic memory_write_n;
	logic address_enable_n;

	modport decoder (
		input address,
		input io_read_n,
		input io_write_n,
		input memory_write_n,
		input address_enable_n
	);

	modport mapper (
		input address,
		input data,
		input io_read_n,
		input io_write_n
	);

	modport readback (
		input address,
		input data,
		input io_read_n,
		input io_write_n,
		input memory_read_n
	);

endinterface

/* verilog/io_decoder.sv */
`timescale 1ns/1ps
`include "chipset_cfg.svh"

module io_decoder import chipset_pkg::*; (
	cpu_bus_if.decoder bus_i,
	input logic ems_enabled_i,
	output logic [`PERIPH_COUNT-1:0] periph_cs_n_o,
	output io_sel_t sel_o,
	output logic ram_write_o
);

	localparam int SEL_W = $clog2(`PERIPH_COUNT);

	logic io_req;
	logic io_cycle;
	logic low_page;

	assign io_req = !bus_i.io_read_n || !bus_i.io_write_n;
	assign io_cycle = io_req && !bus_i.address_enable_n;

	// xt ports 0x000 to 0x0ff
	assign low_page = bus_i.address[9:8] == 2'b00;

	// 32-port blocks, one select each
	always_comb begin
		periph_cs_n_o = '1;
		if (io_cycle && low_page) begin
			periph_cs_n_o[bus_i.address[5 +: SEL_W]] = 1'b0;
		end
	end

	always_comb begin
		sel_o.ems = io_cycle && ems_enabled_i &&
			(bus_i.address[15:2] == 14'(`EMS_PORT_BASE >> 2));
		sel_o.lpt = io_cycle && (bus_i.address[15:0] == 16'(`LPT_PORT));
		sel_o.nmi_mask = io_cycle &&
			(bus_i.address[15:3] == 13'(`NMI_MASK_PORT >> 3));
		// any memory cycle goes to ram
		sel_o.ram = !io_req && !bus_i.address_enable_n;
	end

	assign ram_write_o = sel_o.ram && !bus_i.memory_write_n;

	a_cs_onehot: assert final ($onehot0(~periph_cs_n_o))
		else $error("more than one peripheral select active");

endmodule

/* verilog/ems_mapper.sv */
`timescale 1ns/1ps
`include "chipset_cfg.svh"

module ems_mapper import chipset_pkg::*; (
	input logic clock,
	input logic reset,
	cpu_bus_if.mapper bus_i,
	input io_sel_t sel_i,
	input logic [1:0] ems_base_i,
	output ems_map_t map_o,
	output logic [`EMS_PAGES-1:0] enable_o,
	output ram_addr_t ram_address_o
);

	localparam int PAGE_W = $clog2(`EMS_PAGES);

	logic io_req;
	logic [PAGE_W-1:0] port_page;
	ems_entry_t new_entry;
	logic new_enable;

	// write stage 1
	logic wr_flag;
	logic [PAGE_W-1:0] wr_page;
	ems_entry_t wr_entry;
	logic wr_enable;

	logic [3:0] window_seg;
	logic [PAGE_W-1:0] win_page;
	logic win_hit;

	assign io_req = !bus_i.io_read_n || !bus_i.io_write_n;
	assign port_page = bus_i.address[PAGE_W-1:0];

	// 0xff unmaps, bit 7 set leaves the page alone
	always_comb begin
		new_entry = map_o[port_page];
		new_enable = enable_o[port_page];
		if (bus_i.data == 8'hFF) begin
			new_entry = '1;
			new_enable = 1'b0;
		end else if (bus_i.data < 8'h80) begin
			new_entry = bus_i.data[`EMS_MAP_W-1:0];
			new_enable = 1'b1;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_flag <= 1'b0;
		end else begin
			wr_flag <= sel_i.ems && !bus_i.io_write_n;
		end
	end

	always_ff @(posedge clock) begin
		wr_page <= port_page;
		wr_entry <= new_entry;
		wr_enable <= new_enable;
	end

	// write stage 2
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			map_o <= '0;
			enable_o <= '0;
		end else if (wr_flag) begin
			map_o[wr_page] <= wr_entry;
			enable_o[wr_page] <= wr_enable;
		end
	end

	// window segment, defaults to 0xd000
	always_comb begin
		case (ems_base_i)
			2'd0: window_seg = 4'hA;
			2'd1: window_seg = 4'hC;
			default: window_seg = 4'hD;
		endcase
	end

	assign win_page = bus_i.address[15 -: PAGE_W];
	assign win_hit = !io_req && (bus_i.address[19:16] == window_seg) &&
		enable_o[win_page];

	always_comb begin
		if (win_hit) begin
			ram_address_o = {1'b1, map_o[win_page], bus_i.address[13:0]};
		end else begin
			ram_address_o = {1'b0, bus_i.address};
		end
	end

	// upper half of ram is only reachable through the window
	a_no_ems_on_io: assert property (
		@(posedge clock) disable iff (reset)
		io_req |-> !ram_address_o[`RAM_ADDR_W-1]
	) else $error("ems ram address during i/o cycle");

endmodule

/* verilog/chipset_readback.sv */
`timescale 1ns/1ps
`include "chipset_cfg.svh"

module chipset_readback import chipset_pkg::*; (
	input logic clock,
	input logic reset,
	cpu_bus_if.readback bus_i,
	input io_sel_t sel_i,
	input ems_map_t map_i,
	input logic [`EMS_PAGES-1:0] enable_i,
	input bus_byte_t ram_data_i,
	output bus_byte_t data_bus_out_o,
	output logic data_bus_out_from_chipset_o
);

	localparam int PAGE_W = $clog2(`EMS_PAGES);

	bus_byte_t lpt_data;
	bus_byte_t nmi_mask_data;
	logic [PAGE_W-1:0] rd_page;
	bus_byte_t ems_rd_data;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_data <= 8'hFF;
			nmi_mask_data <= 8'hFF;
		end else begin
			if (sel_i.lpt && !bus_i.io_write_n) begin
				lpt_data <= bus_i.data;
			end
			if (sel_i.nmi_mask && !bus_i.io_write_n) begin
				nmi_mask_data <= bus_i.data;
			end
		end
	end

	// unmapped page reads as 0xff
	assign rd_page = bus_i.address[PAGE_W-1:0];
	assign ems_rd_data = enable_i[rd_page] ?
		{{(8 - `EMS_MAP_W){1'b0}}, map_i[rd_page]} : 8'hFF;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			data_bus_out_from_chipset_o <= 1'b0;
			data_bus_out_o <= '0;
		end else if (sel_i.ram && !bus_i.memory_read_n) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o <= ram_data_i;
		end else if (sel_i.ems && !bus_i.io_read_n) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o <= ems_rd_data;
		end else if (sel_i.lpt && !bus_i.io_read_n) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o <= lpt_data;
		end else if (sel_i.nmi_mask && !bus_i.io_read_n) begin
			data_bus_out_from_chipset_o <= 1'b1;
			data_bus_out_o <= nmi_mask_data;
		end else begin
			data_bus_out_from_chipset_o <= 1'b0;
			data_bus_out_o <= '0;
		end
	end

	// external bus is wire-ored, an idle chipset must drive zeros
	a_idle_zero: assert property (
		@(posedge clock) disable iff (reset)
		!data_bus_out_from_chipset_o |-> (data_bus_out_o == '0)
	) else $error("chipset data not zero while idle");

endmodule

/* verilog/chipset_top.sv */
`timescale 1ns/1ps
`include "chipset_cfg.svh"

module chipset_top import chipset_pkg::*; (
	input logic clock,
	input logic reset,
	input cpu_addr_t address_i,
	input bus_byte_t data_i,
	input logic io_read_n_i,
	input logic io_write_n_i,
	input logic memory_read_n_i,
	input logic memory_write_n_i,
	input logic address_enable_n_i,
	input logic ems_enabled_i,
	input logic [1:0] ems_base_i,
	input bus_byte_t ram_data_i,
	output logic [`PERIPH_COUNT-1:0] periph_cs_n_o,
	output logic ram_select_o,
	output logic ram_write_o,
	output ram_addr_t ram_address_o,
	output bus_byte_t data_bus_out_o,
	output logic data_bus_out_from_chipset_o
);

	cpu_bus_if bus ();

	io_sel_t sel;
	ems_map_t ems_map;
	logic [`EMS_PAGES-1:0] ems_enable;

	assign bus.address = address_i;
	assign bus.data = data_i;
	assign bus.io_read_n = io_read_n_i;
	assign bus.io_write_n = io_write_n_i;
	assign bus.memory_read_n = memory_read_n_i;
	assign bus.memory_write_n = memory_write_n_i;
	assign bus.address_enable_n = address_enable_n_i;

	io_decoder u_io_decoder (
		.bus_i(bus),
		.ems_enabled_i(ems_enabled_i),
		.periph_cs_n_o(periph_cs_n_o),
		.sel_o(sel),
		.ram_write_o(ram_write_o)
	);

	ems_mapper u_ems_mapper (
		.clock(clock),
		.reset(reset),
		.bus_i(bus),
		.sel_i(sel),
		.ems_base_i(ems_base_i),
		.map_o(ems_map),
		.enable_o(ems_enable),
		.ram_address_o(ram_address_o)
	);

	chipset_readback u_chipset_readback (
		.clock(clock),
		.reset(reset),
		.bus_i(bus),
		.sel_i(sel),
		.map_i(ems_map),
		.enable_i(ems_enable),
		.ram_data_i(ram_data_i),
		.data_bus_out_o(data_bus_out_o),
		.data_bus_out_from_chipset_o(data_bus_out_from_chipset_o)
	);

	assign ram_select_o = sel.ram;

endmodule

/* bench/tb_chipset.sv */
`timescale 1ns/1ps
`include "chipset_cfg.svh"

module tb_chipset import chipset_pkg::*; ();

	localparam int TEST_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 5 / 2;
	// strobes as {io_read_n, io_write_n, memory_read_n, memory_write_n}
	localparam logic [3:0] IO_RD = 4'b0111;
	localparam logic [3:0] IO_WR = 4'b1011;
	localparam logic [3:0] MEM_RD = 4'b1101;
	localparam logic [3:0] MEM_WR = 4'b1110;
	localparam logic [3:0] IDLE = 4'b1111;
	// window segment per ems_base_i value
	localparam logic [3:0] WINDOW_SEG [4] = '{4'hA, 4'hC, 4'hD, 4'hD};

	logic clock = 1'b0;
	logic reset = 1'b1;
	cpu_addr_t address_i = '0;
	bus_byte_t data_i = '0;
	logic io_read_n_i = 1'b1;
	logic io_write_n_i = 1'b1;
	logic memory_read_n_i = 1'b1;
	logic memory_write_n_i = 1'b1;
	logic address_enable_n_i = 1'b1;
	logic ems_enabled_i = 1'b0;
	logic [1:0] ems_base_i = 2'd0;
	bus_byte_t ram_data_i = '0;
	logic [`PERIPH_COUNT-1:0] periph_cs_n_o;
	logic ram_select_o;
	logic ram_write_o;
	ram_addr_t ram_address_o;
	bus_byte_t data_bus_out_o;
	logic data_bus_out_from_chipset_o;

	// reference model state
	logic io_req;
	logic ems_hit;
	logic lpt_hit;
	logic nmi_hit;
	logic ram_hit;
	logic [`PERIPH_COUNT-1:0] exp_cs;
	ram_addr_t exp_ram_address;
	ems_entry_t m_map [`EMS_PAGES];
	logic [`EMS_PAGES-1:0] m_enable;
	logic pend_valid;
	logic [1:0] pend_page;
	bus_byte_t pend_data;
	bus_byte_t m_lpt;
	bus_byte_t m_nmi;
	bus_byte_t exp_data;
	logic exp_flag;
	logic [31:0] rng_state = 32'd67;
	int cycle_count = 0;

	chipset_top u_chipset_top (.*);

	always #50 clock = ~clock;

	assign io_req = !io_read_n_i || !io_write_n_i;
	assign ems_hit = io_req && !address_enable_n_i && ems_enabled_i &&
		((address_i[15:0] & 16'hFFFC) == `EMS_PORT_BASE);
	assign lpt_hit = io_req && !address_enable_n_i && (address_i[15:0] == `LPT_PORT);
	assign nmi_hit = io_req && !address_enable_n_i &&
		((address_i[15:0] & 16'hFFF8) == `NMI_MASK_PORT);
	assign ram_hit = !io_req && !address_enable_n_i;

	always_comb begin
		// one 32-port block per select on a 10-bit decode
		for (int k = 0; k < `PERIPH_COUNT; k++) begin
			exp_cs[k] = !(io_req && !address_enable_n_i && address_i[9:5] == 5'(k));
		end
		if (!io_req && address_i[19:16] == WINDOW_SEG[ems_base_i] &&
			m_enable[address_i[15:14]]) begin
			exp_ram_address = {1'b1, m_map[address_i[15:14]], address_i[13:0]};
		end else begin
			exp_ram_address = {1'b0, address_i};
		end
	end

	always @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < `EMS_PAGES; p++)
				m_map[p] <= '0;
			m_enable <= '0;
			pend_valid <= 1'b0;
			m_lpt <= 8'hFF;
			m_nmi <= 8'hFF;
			exp_flag <= 1'b0;
			exp_data <= '0;
		end else begin
			// map lands one edge after the write is sampled
			pend_valid <= ems_hit && !io_write_n_i;
			pend_page <= address_i[1:0];
			pend_data <= data_i;
			if (pend_valid && pend_data == 8'hFF) begin
				m_map[pend_page] <= '1;
				m_enable[pend_page] <= 1'b0;
			end else if (pend_valid && !pend_data[7]) begin
				m_map[pend_page] <= pend_data[`EMS_MAP_W-1:0];
				m_enable[pend_page] <= 1'b1;
			end
			if (lpt_hit && !io_write_n_i)
				m_lpt <= data_i;
			if (nmi_hit && !io_write_n_i)
				m_nmi <= data_i;
			exp_flag <= 1'b1;
			if (ram_hit && !memory_read_n_i)
				exp_data <= ram_data_i;
			else if (ems_hit && !io_read_n_i)
				exp_data <= m_enable[address_i[1:0]] ? {2'b00, m_map[address_i[1:0]]} : 8'hFF;
			else if (lpt_hit && !io_read_n_i)
				exp_data <= m_lpt;
			else if (nmi_hit && !io_read_n_i)
				exp_data <= m_nmi;
			else begin
				exp_flag <= 1'b0;
				exp_data <= '0;
			end
		end
	end

	a_periph_cs: assert property (@(posedge clock) disable iff (reset) periph_cs_n_o == exp_cs)
		else report_error($sformatf("periph_cs_n_o %b, expected %b",
			$sampled(periph_cs_n_o), $sampled(exp_cs)));
	a_ram_ctrl: assert property (@(posedge clock) disable iff (reset)
		(ram_select_o == ram_hit) && (ram_write_o == (ram_hit && !memory_write_n_i)))
		else report_error("ram_select_o or ram_write_o does not follow the memory cycle");
	a_ram_address: assert property (@(posedge clock) disable iff (reset)
		ram_address_o == exp_ram_address)
		else report_error($sformatf("ram_address_o %h, expected %h",
			$sampled(ram_address_o), $sampled(exp_ram_address)));
	a_readback: assert property (@(posedge clock) disable iff (reset)
		(data_bus_out_from_chipset_o == exp_flag) && (data_bus_out_o == exp_data))
		else report_error($sformatf("read-back flag %b data %h, expected %b %h",
			$sampled(data_bus_out_from_chipset_o), $sampled(data_bus_out_o),
			$sampled(exp_flag), $sampled(exp_data)));

	task automatic report_error(input string msg);
		$display("[ERROR] %0d ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	// upper lcg bits folded down since the low ones repeat fast
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state ^ (rng_state >> 15);
	endfunction

	task automatic drive_cycle(input cpu_addr_t a, input bus_byte_t d,
		input logic [3:0] strobes_n);
		logic [31:0] r;
		r = next_random();
		@(posedge clock);
		address_i <= a;
		data_i <= d;
		{io_read_n_i, io_write_n_i, memory_read_n_i, memory_write_n_i} <= strobes_n;
		// aen only floats when nothing is strobed
		address_enable_n_i <= (strobes_n == IDLE) && r[0];
		ram_data_i <= r[7:0];
	endtask

	always @(posedge clock) begin
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$fatal(1, "timeout");
		end else begin
			cycle_count <= cycle_count + 1;
		end
	end

	initial begin
		logic [31:0] r;
		cpu_addr_t a;
		bus_byte_t value;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		// both latches read 0xff straight out of reset
		drive_cycle(cpu_addr_t'(`LPT_PORT), 8'h00, IO_RD);
		drive_cycle(cpu_addr_t'(`NMI_MASK_PORT), 8'h00, IO_RD);

		// low ports, ports at 0x100 and up, then memory cycles
		for (int i = 0; i < 64; i++) begin
			r = next_random();
			a = cpu_addr_t'(r[27:8]);
			if (i < 24)
				a = cpu_addr_t'(r[15:8]);
			else if (i < 48 && a[9:8] == 2'b00)
				a[8] = 1'b1;
			drive_cycle(a, r[23:16], (i >= 48) ? (r[1] ? MEM_WR : MEM_RD) :
				(r[1] ? IO_RD : IO_WR));
		end

		ems_enabled_i <= 1'b1;
		for (int i = 0; i < 28; i++) begin
			r = next_random();
			case ((i < 4) ? 2'd1 : r[9:8])
				2'd0: value = 8'hFF;
				// bit 7 set but never 0xff
				2'd3: value = {1'b1, r[6:1], 1'b0};
				default: value = {1'b0, r[6:0]};
			endcase
			a = cpu_addr_t'(`EMS_PORT_BASE + i % 4);
			drive_cycle(a, value, IO_WR);
			drive_cycle(a, 8'h00, IDLE);
			drive_cycle(a, 8'h00, IO_RD);
			drive_cycle(a, 8'h00, IDLE);
		end

		// with ems off the map must hold
		ems_enabled_i <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			drive_cycle(cpu_addr_t'(`EMS_PORT_BASE + r[1:0]), {1'b0, r[14:8]}, IO_WR);
			drive_cycle(a, 8'h00, IDLE);
		end
		ems_enabled_i <= 1'b1;
		// pages 0 to 2 mapped, page 3 left unmapped
		for (int p = 0; p < `EMS_PAGES; p++) begin
			r = next_random();
			a = cpu_addr_t'(`EMS_PORT_BASE + p);
			drive_cycle(a, 8'h00, IO_RD);
			drive_cycle(a, (p == 3) ? 8'hFF : {2'b00, r[13:8]}, IO_WR);
			drive_cycle(a, 8'h00, IDLE);
		end

		for (int b = 0; b < 4; b++) begin
			ems_base_i <= 2'(b);
			for (int i = 0; i < 14; i++) begin
				r = next_random();
				a = cpu_addr_t'(r[27:8]);
				if (i % 2 == 0)
					a[19:16] = WINDOW_SEG[b];
				drive_cycle(a, 8'h00, (i >= 12) ? IO_RD : (r[1] ? MEM_WR : MEM_RD));
			end
		end

		for (int i = 0; i < 8; i++) begin
			r = next_random();
			drive_cycle(cpu_addr_t'(`LPT_PORT), r[7:0], IO_WR);
			drive_cycle(cpu_addr_t'(`LPT_PORT), 8'h00, IO_RD);
			drive_cycle(cpu_addr_t'(`NMI_MASK_PORT + r[10:8]), r[23:16], IO_WR);
			drive_cycle(cpu_addr_t'(`NMI_MASK_PORT + r[13:11]), 8'h00, IO_RD);
		end

		for (int i = 0; i < 16; i++) begin
			r = next_random();
			drive_cycle(cpu_addr_t'(r[27:8]), 8'h00, MEM_RD);
			drive_cycle(cpu_addr_t'(r[31:12]), 8'h00, IDLE);
		end
		drive_cycle('0, 8'h00, IDLE);
		repeat (2) @(posedge clock);
		$display("Verification passed");
		$finish;
	end

endmodule

/* src.f */
+incdir+verilog
verilog/chipset_pkg.sv
verilog/cpu_bus_if.sv
verilog/io_decoder.sv
verilog/ems_mapper.sv
verilog/chipset_readback.sv
verilog/chipset_top.sv
bench/tb_chipset.sv
